//--- ddr3_read_path.f
hw/ddr3_read_pkg.sv
hw/read_job_if.sv
hw/ddr3_read_fifo.sv
hw/ddr3_read_ctrl.sv
hw/ddr3_word_streamer.sv
hw/ddr3_read_path.sv
tb/ddr3_mem_model.sv
tb/tb_ddr3_read_path.sv

//--- Bender.yml
package:
  name: ddr3_read_path

sources:
  - files:
      - hw/ddr3_read_pkg.sv
      - hw/read_job_if.sv
      - hw/ddr3_read_fifo.sv
      - hw/ddr3_read_ctrl.sv
      - hw/ddr3_word_streamer.sv
      - hw/ddr3_read_path.sv
  - target: test
    files:
      - tb/ddr3_mem_model.sv
      - tb/tb_ddr3_read_path.sv

//--- tb/tb_ddr3_read_path.sv
module tb_ddr3_read_path import ddr3_read_pkg::*; ();

    localparam int REQ_TIMEOUT  = 1000;
    localparam int DATA_TIMEOUT = 20000;

    logic       clk;
    logic       rst;

    word_addr_t rd_addr;
    req_len_t   rd_len;
    txn_id_t    rd_id;
    logic       rd_addr_valid;
    logic       rd_addr_ready;
    word_t      rd_data;
    logic       rd_data_last;
    txn_id_t    rd_back_id;
    logic       rd_data_valid;
    logic       rd_data_ready;

    word_addr_t read_addr;
    ddr_len_t   read_len;
    txn_id_t    read_id;
    logic       read_addr_valid;
    logic       read_addr_ready;
    beat_t      read_data;
    txn_id_t    read_back_id;
    logic       read_data_last;
    logic       read_data_valid;

    int          error_count;
    int          check_count;
    logic [31:0] lfsr;

    ddr3_read_path u_ddr3_read_path (
        .clk             (clk),
        .rst             (rst),
        .rd_addr         (rd_addr),
        .rd_len          (rd_len),
        .rd_id           (rd_id),
        .rd_addr_valid   (rd_addr_valid),
        .rd_addr_ready   (rd_addr_ready),
        .rd_data         (rd_data),
        .rd_data_last    (rd_data_last),
        .rd_back_id      (rd_back_id),
        .rd_data_valid   (rd_data_valid),
        .rd_data_ready   (rd_data_ready),
        .read_addr       (read_addr),
        .read_len        (read_len),
        .read_id         (read_id),
        .read_addr_valid (read_addr_valid),
        .read_addr_ready (read_addr_ready),
        .read_data       (read_data),
        .read_back_id    (read_back_id),
        .read_data_last  (read_data_last),
        .read_data_valid (read_data_valid)
    );

    ddr3_mem_model #(.SEED(32'h6668_dea8)) u_mem_model (
        .clk             (clk),
        .read_addr       (read_addr),
        .read_len        (read_len),
        .read_id         (read_id),
        .read_addr_valid (read_addr_valid),
        .read_addr_ready (read_addr_ready),
        .read_data       (read_data),
        .read_back_id    (read_back_id),
        .read_data_last  (read_data_last),
        .read_data_valid (read_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    // memory content follows from the word address alone
    function automatic word_t expected_word(input word_addr_t a);
        return word_t'(a) ^ 32'h5a5a_0000;
    endfunction

    task automatic check_word(input string name, input word_t act, input word_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_id(input string name, input txn_id_t act, input txn_id_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input word_addr_t act, input word_addr_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_len(input string name, input ddr_len_t act, input ddr_len_t exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic print_summary();
        $display("checks: %0d, errors: %0d", check_count, error_count);
    endtask

    task automatic abort_run(input string what);
        error_count++;
        $display("Timed out waiting for %s at %0t", what, $time);
        print_summary();
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic send_request(input word_addr_t addr, input req_len_t len, input txn_id_t id);
        int cycles;
        cycles = 0;
        while (rd_addr_ready !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                abort_run("rd_addr_ready");
            end
        end
        rd_addr       = addr;
        rd_len        = len;
        rd_id         = id;
        rd_addr_valid = 1'b1;
        @(posedge clk);
        #1;
        rd_addr_valid = 1'b0;
    endtask

    // take words in order with optional random ready gaps
    task automatic collect_words(input word_addr_t addr, input int nwords,
                                 input txn_id_t id, input bit gaps);
        int    got;
        int    cycles;
        logic  rdy;
        logic  stalled;
        word_t held_word;
        logic  held_last;
        got     = 0;
        cycles  = 0;
        stalled = 1'b0;
        while (got < nwords) begin
            rdy           = gaps ? (take_bits(2) != 0) : 1'b1;
            rd_data_ready = rdy;
            // a stalled word must hold until taken
            if (stalled) begin
                check_flag("rd_data_valid", rd_data_valid, 1'b1);
                check_word("rd_data", rd_data, held_word);
                check_flag("rd_data_last", rd_data_last, held_last);
            end
            stalled = 1'b0;
            if (rd_data_valid === 1'b1) begin
                if (rdy) begin
                    check_word("rd_data", rd_data, expected_word(addr + word_addr_t'(got)));
                    check_id("rd_back_id", rd_back_id, id);
                    check_flag("rd_data_last", rd_data_last, got == nwords - 1);
                    got++;
                end else begin
                    stalled   = 1'b1;
                    held_word = rd_data;
                    held_last = rd_data_last;
                end
            end
            cycles++;
            if (cycles > DATA_TIMEOUT) begin
                abort_run("the last data word");
            end
            @(posedge clk);
            #1;
        end
        rd_data_ready = 1'b0;
    endtask

    // flush cycle after the done cycle and then idle again
    task automatic check_turnaround();
        check_flag("rd_addr_ready", rd_addr_ready, 1'b0);
        check_flag("rd_data_valid", rd_data_valid, 1'b0);
        @(posedge clk);
        #1;
        check_flag("rd_addr_ready", rd_addr_ready, 1'b1);
        check_flag("rd_data_valid", rd_data_valid, 1'b0);
    endtask

    task automatic check_bursts(input word_addr_t addr, input req_len_t len,
                                input txn_id_t id, input int first);
        word_addr_t beat_addr;
        int         first_beat;
        int         last_beat;
        int         remaining;
        int         n;
        int         idx;
        first_beat = int'(addr) / WORDS_PER_BEAT;
        last_beat  = (int'(addr) + int'(len)) / WORDS_PER_BEAT;
        beat_addr  = word_addr_t'(first_beat * WORDS_PER_BEAT);
        remaining  = last_beat - first_beat + 1;
        idx        = first;
        while (remaining > 0) begin
            n = (remaining > MAX_BURST_BEATS) ? MAX_BURST_BEATS : remaining;
            if (idx >= u_mem_model.burst_count) begin
                error_count++;
                $display("DDR3 burst at address 0x%h was never issued", beat_addr);
                break;
            end
            check_addr("read_addr", u_mem_model.burst_addr[idx], beat_addr);
            check_len("read_len", u_mem_model.burst_len[idx], ddr_len_t'(n - 1));
            check_id("read_id", u_mem_model.burst_id[idx], id);
            beat_addr = beat_addr + word_addr_t'(n * WORDS_PER_BEAT);
            remaining = remaining - n;
            idx++;
        end
        if (remaining == 0 && idx != u_mem_model.burst_count) begin
            error_count++;
            $display("DDR3 saw %0d bursts for one request, expected %0d",
                     u_mem_model.burst_count - first, idx - first);
        end
    endtask

    task automatic run_read(input word_addr_t addr, input req_len_t len,
                            input txn_id_t id, input bit gaps);
        int first;
        first = u_mem_model.burst_count;
        send_request(addr, len, id);
        collect_words(addr, int'(len) + 1, id, gaps);
        check_turnaround();
        check_bursts(addr, len, id, first);
    endtask

    task automatic test_aligned_read();
        run_read(28'h000_0100, 8'd7, 4'h1, 1'b0);
    endtask

    task automatic test_unaligned_read();
        run_read(28'h000_0205, 8'd5, 4'h2, 1'b0);
    endtask

    task automatic test_long_read();
        run_read(28'h000_1003, 8'd199, 4'h3, 1'b0);
    endtask

    task automatic test_long_read_stalled();
        run_read(28'h000_1003, 8'd199, 4'h4, 1'b1);
    endtask

    task automatic test_id_and_turnaround();
        run_read(28'h000_0a06, 8'd33, 4'he, 1'b1);
        run_read(28'h000_0b01, 8'd2, 4'h9, 1'b0);
    endtask

    // first request stops mid beat and leaves tail words for the flush
    task automatic test_back_to_back();
        run_read(28'h000_0303, 8'd9, 4'h6, 1'b0);
        run_read(28'h000_040a, 8'd20, 4'h7, 1'b0);
    endtask

    initial begin
        error_count   = 0;
        check_count   = 0;
        lfsr          = 32'h6668_dea8;
        rst           = 1'b1;
        rd_addr       = '0;
        rd_len        = '0;
        rd_id         = '0;
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_flag("rd_addr_ready", rd_addr_ready, 1'b1);
        check_flag("rd_data_valid", rd_data_valid, 1'b0);
        check_flag("rd_data_last", rd_data_last, 1'b0);
        check_flag("read_addr_valid", read_addr_valid, 1'b0);

        test_aligned_read();
        test_unaligned_read();
        test_long_read();
        test_long_read_stalled();
        test_id_and_turnaround();
        test_back_to_back();

        print_summary();
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/ddr3_mem_model.sv
module ddr3_mem_model import ddr3_read_pkg::*; #(
    parameter logic [31:0] SEED = 32'h6668_dea8
) (
    input  logic       clk,
    input  word_addr_t read_addr,
    input  ddr_len_t   read_len,
    input  txn_id_t    read_id,
    input  logic       read_addr_valid,
    output logic       read_addr_ready,
    output beat_t      read_data,
    output txn_id_t    read_back_id,
    output logic       read_data_last,
    output logic       read_data_valid
);

    // log of accepted bursts for the testbench
    word_addr_t  burst_addr [256];
    ddr_len_t    burst_len  [256];
    txn_id_t     burst_id   [256];
    int          burst_count;

    logic [31:0] lfsr;

    // galois LFSR stepped once per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    // word k of beat B holds address B+k xor a fixed pattern
    function automatic beat_t make_beat(input word_addr_t base);
        beat_t b;
        for (int k = 0; k < WORDS_PER_BEAT; k++) begin
            b[k*32 +: 32] = word_t'(base + word_addr_t'(k)) ^ 32'h5a5a_0000;
        end
        return b;
    endfunction

    initial begin
        word_addr_t addr;
        ddr_len_t   len;
        txn_id_t    id;
        int         delay;
        lfsr            = SEED;
        burst_count     = 0;
        read_addr_ready = 1'b0;
        read_data       = '0;
        read_back_id    = '0;
        read_data_last  = 1'b0;
        read_data_valid = 1'b0;
        // responder idles here between bursts
        forever begin
            @(posedge clk);
            #1;
            if (read_addr_valid === 1'b1) begin
                delay = take_bits(2);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                addr            = read_addr;
                len             = read_len;
                id              = read_id;
                read_addr_ready = 1'b1;
                @(posedge clk);
                #1;
                read_addr_ready = 1'b0;
                if (burst_count < 256) begin
                    burst_addr[burst_count] = addr;
                    burst_len[burst_count]  = len;
                    burst_id[burst_count]   = id;
                end
                burst_count++;
                for (int beat = 0; beat <= int'(len); beat++) begin
                    delay = take_bits(2);
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                    read_data       = make_beat(addr + word_addr_t'(beat * WORDS_PER_BEAT));
                    read_back_id    = id;
                    read_data_last  = (beat == int'(len));
                    read_data_valid = 1'b1;
                    @(posedge clk);
                    #1;
                    read_data_valid = 1'b0;
                    read_data_last  = 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/ddr3_read_path.sv
module ddr3_read_path import ddr3_read_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // client address channel
    input  word_addr_t rd_addr,
    input  req_len_t   rd_len,
    input  txn_id_t    rd_id,
    input  logic       rd_addr_valid,
    output logic       rd_addr_ready,

    // client data channel
    output word_t      rd_data,
    output logic       rd_data_last,
    output txn_id_t    rd_back_id,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,

    // DDR3 address channel
    output word_addr_t read_addr,
    output ddr_len_t   read_len,
    output txn_id_t    read_id,
    output logic       read_addr_valid,
    input  logic       read_addr_ready,

    // DDR3 data channel, in order, so the back ID is not needed to steer beats
    input  beat_t      read_data,
    input  txn_id_t    read_back_id,
    input  logic       read_data_last,
    input  logic       read_data_valid
);

    word_t fifo_rd_data;
    logic  fifo_rd_en;
    logic  fifo_empty;
    logic  fifo_refill;

    read_job_if job ();

    ddr3_read_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .rd_addr         (rd_addr),
        .rd_len          (rd_len),
        .rd_id           (rd_id),
        .rd_addr_valid   (rd_addr_valid),
        .rd_addr_ready   (rd_addr_ready),
        .read_addr       (read_addr),
        .read_len        (read_len),
        .read_id         (read_id),
        .read_addr_valid (read_addr_valid),
        .read_addr_ready (read_addr_ready),
        .read_data_valid (read_data_valid),
        .read_data_last  (read_data_last),
        .refill          (fifo_refill),
        .job             (job)
    );

    ddr3_word_streamer u_streamer (
        .clk           (clk),
        .rst           (rst),
        .job           (job),
        .empty         (fifo_empty),
        .rd_en         (fifo_rd_en),
        .fifo_data     (fifo_rd_data),
        .rd_data       (rd_data),
        .rd_data_last  (rd_data_last),
        .rd_back_id    (rd_back_id),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready)
    );

    ddr3_read_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .flush   (job.flush),
        .wr_en   (read_data_valid),
        .wr_data (read_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty),
        .refill  (fifo_refill)
    );

endmodule

//--- hw/ddr3_word_streamer.sv
module ddr3_word_streamer import ddr3_read_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    read_job_if.streamer job,

    // FIFO read side
    input  logic         empty,
    output logic         rd_en,
    input  word_t        fifo_data,

    // client data channel
    output word_t        rd_data,
    output logic         rd_data_last,
    output txn_id_t      rd_back_id,
    output logic         rd_data_valid,
    input  logic         rd_data_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_skip,
        st_stream,
        st_drain
    } strm_state_t;

    strm_state_t state;
    word_sel_t   skip_q;
    req_len_t    left_q;
    txn_id_t     id_q;

    // FIFO output register holds a word meant for the client
    logic        primed;
    logic        handshake;

    assign rd_data_valid = (state == st_stream) && primed;
    assign rd_data_last  = rd_data_valid && (left_q == '0);
    assign handshake     = rd_data_valid && rd_data_ready;
    assign job.done      = handshake && rd_data_last;

    assign rd_data    = fifo_data;
    assign rd_back_id = id_q;

    // discard leading words, then fetch a word when the output slot frees up.
    // no read past the last word, the tail is left for the flush
    assign rd_en = !empty && ((state == st_skip) ||
                   ((state == st_stream) && (!primed || (handshake && !rd_data_last))));

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            skip_q <= '0;
            left_q <= '0;
            primed <= 1'b0;
        end else if (job.flush) begin
            state  <= st_idle;
            primed <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (job.start) begin
                        skip_q <= job.skip;
                        left_q <= job.words;
                        primed <= 1'b0;
                        state  <= (job.skip != '0) ? st_skip : st_stream;
                    end
                end
                st_skip: begin
                    if (rd_en) begin
                        skip_q <= skip_q - 1'b1;
                        if (skip_q == word_sel_t'(1)) begin
                            state <= st_stream;
                        end
                    end
                end
                st_stream: begin
                    if (rd_en) begin
                        primed <= 1'b1;
                    end else if (handshake) begin
                        primed <= 1'b0;
                    end
                    if (job.done) begin
                        state <= st_drain;
                    end else if (handshake) begin
                        left_q <= left_q - 1'b1;
                    end
                end
                // hold until the controller flushes
                st_drain: state <= st_drain;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && job.start) begin
            id_q <= job.id;
        end
    end

endmodule

//--- hw/ddr3_read_ctrl.sv
module ddr3_read_ctrl import ddr3_read_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // client address channel
    input  word_addr_t rd_addr,
    input  req_len_t   rd_len,
    input  txn_id_t    rd_id,
    input  logic       rd_addr_valid,
    output logic       rd_addr_ready,

    // DDR3 address channel
    output word_addr_t read_addr,
    output ddr_len_t   read_len,
    output txn_id_t    read_id,
    output logic       read_addr_valid,
    input  logic       read_addr_ready,

    // DDR3 data channel, burst end only
    input  logic       read_data_valid,
    input  logic       read_data_last,

    input  logic       refill,
    read_job_if.ctrl   job
);

    typedef enum logic [2:0] {
        st_idle,
        st_wait,
        st_send_addr,
        st_recv_data,
        st_flush
    } ctrl_state_t;

    ctrl_state_t state;
    word_addr_t  addr_q;
    beat_cnt_t   beats_q;
    txn_id_t     id_q;

    logic        accept;
    logic        burst_end;
    word_addr_t  last_word;
    beat_cnt_t   total_beats;
    beat_cnt_t   burst_beats;

    assign accept    = rd_addr_valid && rd_addr_ready;
    assign burst_end = (state == st_recv_data) && read_data_valid && read_data_last;

    // beats touched by the request, from first word's beat to last word's beat
    assign last_word   = rd_addr + word_addr_t'(rd_len);
    assign total_beats = beat_cnt_t'((last_word >> $clog2(WORDS_PER_BEAT))
                                   - (rd_addr >> $clog2(WORDS_PER_BEAT)) + 1'b1);

    // next burst is the rest of the request, capped at 16 beats
    assign burst_beats = (beats_q > beat_cnt_t'(MAX_BURST_BEATS)) ?
                         beat_cnt_t'(MAX_BURST_BEATS) : beats_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            beats_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        beats_q <= total_beats;
                        state   <= refill ? st_send_addr : st_wait;
                    end
                end
                st_wait: begin
                    // last word goes out only after the final burst has landed
                    if (job.done) begin
                        state <= st_flush;
                    end else if (beats_q != '0 && refill) begin
                        state <= st_send_addr;
                    end
                end
                st_send_addr: begin
                    if (read_addr_ready) begin
                        state <= st_recv_data;
                    end
                end
                st_recv_data: begin
                    if (burst_end) begin
                        beats_q <= beats_q - burst_beats;
                        state   <= st_wait;
                    end
                end
                st_flush: state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // align down to the beat holding the first word
            addr_q <= rd_addr & ~word_addr_t'(WORDS_PER_BEAT - 1);
            id_q   <= rd_id;
        end else if (burst_end) begin
            addr_q <= addr_q + word_addr_t'(burst_beats * WORDS_PER_BEAT);
        end
    end

    assign rd_addr_ready   = (state == st_idle);

    assign read_addr       = addr_q;
    assign read_len        = ddr_len_t'(burst_beats - 1'b1);
    assign read_id         = id_q;
    assign read_addr_valid = (state == st_send_addr);

    // job info for the streamer, valid with the start pulse
    assign job.start = accept;
    assign job.skip  = word_sel_t'(rd_addr);
    assign job.words = rd_len;
    assign job.id    = rd_id;
    assign job.flush = (state == st_flush);

endmodule

//--- hw/ddr3_read_fifo.sv
module ddr3_read_fifo import ddr3_read_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    input  logic  wr_en,
    input  beat_t wr_data,
    input  logic  rd_en,
    output word_t rd_data,
    output logic  empty,
    output logic  refill
);

    beat_t     mem [FIFO_DEPTH_BEATS];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    word_sel_t rd_word;
    fifo_ptr_t level;
    logic      rd_fire;
    logic      last_word;

    // beats stored, the beat being read counts until its eighth word
    assign level     = wr_ptr - rd_ptr;
    assign empty     = (wr_ptr == rd_ptr);
    assign refill    = (level <= REFILL_LEVEL);

    assign rd_fire   = rd_en && !empty;
    assign last_word = (rd_word == word_sel_t'(WORDS_PER_BEAT - 1));

    // beat side write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[$bits(fifo_ptr_t)-2:0]] <= wr_data;
        end
    end

    // word side read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data <= mem[rd_ptr[$bits(fifo_ptr_t)-2:0]][rd_word*$bits(word_t) +: $bits(word_t)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rd_word <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                // word index wraps on its own after the eighth word
                rd_word <= rd_word + 1'b1;
                if (last_word) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/read_job_if.sv
interface read_job_if import ddr3_read_pkg::*; ();

    // request handed from the controller to the streamer
    logic      start;
    word_sel_t skip;
    req_len_t  words;
    txn_id_t   id;

    // end of request handshake
    logic      done;
    logic      flush;

    modport ctrl (
        output start, skip, words, id, flush,
        input  done
    );

    modport streamer (
        input  start, skip, words, id, flush,
        output done
    );

endinterface

//--- hw/ddr3_read_pkg.sv
package ddr3_read_pkg;

    // buffer and burst sizing
    localparam int WORDS_PER_BEAT   = 8;
    localparam int MAX_BURST_BEATS  = 16;
    localparam int FIFO_DEPTH_BEATS = 32;

    // a new burst may start only at or below this many stored beats.
    // one burst in flight at a time, so the buffer never overflows
    localparam int REFILL_LEVEL     = 16;

    // word address, counts 32-bit words
    typedef logic [27:0]  word_addr_t;

    // one client word
    typedef logic [31:0]  word_t;

    // one DDR3 data beat, eight words
    typedef logic [255:0] beat_t;

    // client length, words minus one
    typedef logic [7:0]   req_len_t;

    // DDR3 burst length, beats minus one
    typedef logic [3:0]   ddr_len_t;

    typedef logic [3:0]   txn_id_t;

    // word position inside a beat
    typedef logic [2:0]   word_sel_t;

    // beats still to fetch for one request
    typedef logic [5:0]   beat_cnt_t;

    // beat pointer with one extra wrap bit
    typedef logic [$clog2(FIFO_DEPTH_BEATS):0] fifo_ptr_t;

endpackage
